/* source/smon_pkg.sv */
// shared sizes, register map, control fields and types, imported by every monitor block
`default_nettype none

package smon_pkg;

  // --------------------
  // sizes
  // --------------------

  // number of monitored lanes, fixed for this monitor
  localparam int SMON_LANES  = 8;
  // number of host-visible registers
  localparam int SMON_REGS   = 8;
  // register and lane word width
  localparam int SMON_DATA_W = 32;
  // width of one lane select field in the control register
  localparam int SMON_SEL_W  = $clog2(SMON_LANES);

  typedef logic [SMON_DATA_W-1:0] smon_word_t;

  // what a counter does with a matching sample
  typedef enum logic [1:0] {
    MODE_COUNT = 2'd0,
    MODE_SUM   = 2'd1,
    MODE_MAX   = 2'd2
  } smon_mode_e;

  // --------------------
  // register map
  // --------------------

  localparam int REG_CTRL      = 0;
  localparam int REG_CMP0      = 1;
  localparam int REG_CMP1      = 2;
  localparam int REG_CNT0      = 3;
  localparam int REG_CNT1      = 4;
  localparam int REG_THRESH    = 5;
  localparam int REG_TIMER     = 6;
  localparam int REG_TIMER_MAX = 7;

  // control register fields, the remaining bits are plain storage
  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_MODE_LSB = 1;
  localparam int CTRL_SEL0_LSB = 4;
  localparam int CTRL_SEL1_LSB = 8;

endpackage

`default_nettype wire

/* source/smon_cfg_if.sv */
// register access bundle shared by the decode, counting engine and threshold stages
`timescale 1ns/1ns
`default_nettype none

interface smon_cfg_if
  import smon_pkg::*;
();

  // one write pulse per register, already qualified by the one-hot check
  logic [SMON_REGS-1:0] wr;
  // data for whichever register is being written
  smon_word_t           wdata;
  // current contents of all registers, held in the engine
  smon_word_t           regs [SMON_REGS];
  // enable bit with the external disable folded in
  logic                 enabled;

  // host side, produces writes and needs the contents for read-back
  modport decode (
    output wr,
    output wdata,
    input  regs
  );

  // owner of the register file
  modport engine (
    input  wr,
    input  wdata,
    output regs,
    output enabled
  );

  // observer only
  modport result (
    input regs,
    input enabled
  );

endinterface

`default_nettype wire

/* source/smon_cfg_decode.sv */
// host register access: one-hot check of the strobes, write forwarding and read mux
`timescale 1ns/1ns
`default_nettype none

module smon_cfg_decode
  import smon_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [SMON_REGS-1:0] cfg_write,
  input  logic [SMON_REGS-1:0] cfg_read,
  input  smon_word_t           cfg_wdata,
  output logic                 cfg_ack,
  output logic                 cfg_err,
  output smon_word_t           cfg_rdata,
  smon_cfg_if.decode           bus
);

  // read and write strobes together, at most one bit of these may be set
  logic [2*SMON_REGS-1:0] strobes;

  assign strobes = {cfg_read, cfg_write};

  // --------------------
  // acknowledge and error
  // --------------------

  // every access is answered in its own cycle, good or bad
  assign cfg_ack = |strobes;

  // two or more strobe bits in one cycle make the whole access invalid,
  // this also covers a read and a write issued together
  assign cfg_err = !$onehot0(strobes);

  // --------------------
  // write path
  // --------------------

  // a rejected access must not touch any register
  assign bus.wr    = cfg_err ? '0 : cfg_write;
  // the data can go out unconditionally, it only matters with a pulse on wr
  assign bus.wdata = cfg_wdata;

  // --------------------
  // read path
  // --------------------

  // read data is combinational so the value comes back in the strobe cycle,
  // zero when nothing is read or the access was rejected
  always_comb begin
    cfg_rdata = '0;
    if (!cfg_err) begin
      for (int i = 0; i < SMON_REGS; i++) begin
        if (cfg_read[i]) begin
          cfg_rdata = bus.regs[i];
        end
      end
    end
  end

  // a write pulse reaches the engine only for an access with exactly one
  // strobe bit, an invalid access would otherwise commit on the next edge
  a_no_write_on_err : assert property (
    @(posedge clk) disable iff (!arst_n)
    (bus.wr != '0) |-> $onehot({cfg_read, cfg_write})
  );

endmodule

`default_nettype wire

/* source/smon_counter.sv */
// counting engine: register file, lane select and compare, two counters, cycle timer
`timescale 1ns/1ns
`default_nettype none

module smon_counter
  import smon_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  disable_smon,
  input  logic [SMON_LANES-1:0] mon_v,
  input  smon_word_t            mon_comp [SMON_LANES],
  input  smon_word_t            mon_val  [SMON_LANES],
  smon_cfg_if.engine            bus
);

  smon_word_t            regs_q [SMON_REGS];
  smon_word_t            regs_d [SMON_REGS];
  smon_mode_e            mode;
  logic [SMON_SEL_W-1:0] sel [2];
  smon_word_t            cmp [2];
  smon_word_t            cnt [2];
  logic [1:0]            hit;
  logic                  enabled;
  logic                  timer_done;

  // new counter value for a matching sample, unknown mode codes hold the count
  function automatic smon_word_t next_count(smon_mode_e m, smon_word_t c, smon_word_t v);
    smon_word_t res;
    case (m)
      MODE_COUNT: res = c + smon_word_t'(1);
      MODE_SUM:   res = c + v;
      MODE_MAX:   res = (v > c) ? v : c;
      default:    res = c;
    endcase
    return res;
  endfunction

  // --------------------
  // control decode
  // --------------------

  // the external disable overrides the enable bit without changing it
  assign enabled = regs_q[REG_CTRL][CTRL_EN_BIT] && !disable_smon;
  assign mode    = smon_mode_e'(regs_q[REG_CTRL][CTRL_MODE_LSB +: 2]);
  assign sel[0]  = regs_q[REG_CTRL][CTRL_SEL0_LSB +: SMON_SEL_W];
  assign sel[1]  = regs_q[REG_CTRL][CTRL_SEL1_LSB +: SMON_SEL_W];
  assign cmp[0]  = regs_q[REG_CMP0];
  assign cmp[1]  = regs_q[REG_CMP1];
  assign cnt[0]  = regs_q[REG_CNT0];
  assign cnt[1]  = regs_q[REG_CNT1];

  // each counter looks at one lane, a hit needs valid and an exact tag match
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      hit[k] = enabled && mon_v[sel[k]] && (mon_comp[sel[k]] == cmp[k]);
    end
  end

  // timer has reached its limit, this edge stops it and drops the enable bit
  assign timer_done = enabled && (regs_q[REG_TIMER] == regs_q[REG_TIMER_MAX]);

  // --------------------
  // next register state
  // --------------------

  always_comb begin
    regs_d = regs_q;
    if (timer_done) begin
      regs_d[REG_CTRL][CTRL_EN_BIT] = 1'b0;
    end else if (enabled) begin
      regs_d[REG_TIMER] = regs_q[REG_TIMER] + smon_word_t'(1);
    end
    if (hit[0]) begin
      regs_d[REG_CNT0] = next_count(mode, cnt[0], mon_val[sel[0]]);
    end
    if (hit[1]) begin
      regs_d[REG_CNT1] = next_count(mode, cnt[1], mon_val[sel[1]]);
    end
    // host writes come last so they win over any update in the same cycle
    for (int i = 0; i < SMON_REGS; i++) begin
      if (bus.wr[i]) begin
        regs_d[i] = bus.wdata;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < SMON_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      regs_q <= regs_d;
    end
  end

  assign bus.regs    = regs_q;
  assign bus.enabled = enabled;

  // while disabled only the host may move a counter
  a_cnt0_frozen : assert property (
    @(posedge clk) disable iff (!arst_n)
    (!enabled && !bus.wr[REG_CNT0]) |=> $stable(regs_q[REG_CNT0])
  );

  a_cnt1_frozen : assert property (
    @(posedge clk) disable iff (!arst_n)
    (!enabled && !bus.wr[REG_CNT1]) |=> $stable(regs_q[REG_CNT1])
  );

endmodule

`default_nettype wire

/* source/smon_threshold.sv */
// threshold stage: one-cycle interrupt when counter 0 first rises above the threshold
`timescale 1ns/1ns
`default_nettype none

module smon_threshold
  import smon_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  smon_cfg_if.result bus,
  output logic       smon_interrupt
);

  // counter 0 is above the threshold in this cycle
  logic above;
  // same comparison one cycle earlier
  logic above_q;

  // --------------------
  // compare
  // --------------------

  // unsigned compare, equal to the threshold does not count as above
  assign above = bus.regs[REG_CNT0] > bus.regs[REG_THRESH];

  // the history is kept even while disabled so that re-enabling with the
  // counter already above the threshold does not fire a stale interrupt
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      above_q <= 1'b0;
    end else begin
      above_q <= above;
    end
  end

  // --------------------
  // interrupt
  // --------------------

  // the counter moves at an edge, so the crossing is seen as above high and
  // above_q still low in the cycle right after that edge, the next edge
  // catches above_q up and ends the pulse
  assign smon_interrupt = bus.enabled && above && !above_q;

  // one crossing gives exactly one pulse, back to back pulses would mean the
  // history register is not tracking the compare
  a_int_single_cycle : assert property (
    @(posedge clk) disable iff (!arst_n)
    smon_interrupt |=> !smon_interrupt
  );

endmodule

`default_nettype wire

/* source/smon_top.sv */
// statistics monitor top level, plain host and lane ports around the three stages
`timescale 1ns/1ns
`default_nettype none

module smon_top
  import smon_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  disable_smon,
  input  logic [SMON_REGS-1:0]  cfg_write,
  input  logic [SMON_REGS-1:0]  cfg_read,
  input  smon_word_t            cfg_wdata,
  output logic                  cfg_ack,
  output logic                  cfg_err,
  output smon_word_t            cfg_rdata,
  input  logic [SMON_LANES-1:0] mon_v,
  input  smon_word_t            mon_comp [SMON_LANES],
  input  smon_word_t            mon_val  [SMON_LANES],
  output logic                  smon_interrupt,
  output logic                  smon_enabled
);

  // register writes, contents and the enable level between the stages
  smon_cfg_if cfg_bus ();

  // --------------------
  // decode stage
  // --------------------

  smon_cfg_decode i_smon_cfg_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_write (cfg_write),
    .cfg_read  (cfg_read),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_err   (cfg_err),
    .cfg_rdata (cfg_rdata),
    .bus       (cfg_bus.decode)
  );

  // --------------------
  // execute and result stages
  // --------------------

  smon_counter i_smon_counter (
    .clk          (clk),
    .arst_n       (arst_n),
    .disable_smon (disable_smon),
    .mon_v        (mon_v),
    .mon_comp     (mon_comp),
    .mon_val      (mon_val),
    .bus          (cfg_bus.engine)
  );

  smon_threshold i_smon_threshold (
    .clk            (clk),
    .arst_n         (arst_n),
    .bus            (cfg_bus.result),
    .smon_interrupt (smon_interrupt)
  );

  // enable level as seen by the engine, external disable included
  assign smon_enabled = cfg_bus.enabled;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// clock and reset source for the monitor testbench, 10 ns period and reset held for 10 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset is released on a falling edge, away from the active clock edge
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_smon_top.sv */
// table-driven testbench for the statistics monitor, simulation top with its own reference model
`timescale 1ns/1ns
`default_nettype none

module tb_smon_top
  import smon_pkg::*;
();

  localparam int MAX_STEPS = 160;
  localparam smon_word_t TAG0 = 32'hCAFE_0003;
  localparam smon_word_t TAG1 = 32'hBEEF_0005;

  logic                  clk;
  logic                  arst_n;
  logic                  disable_smon;
  logic [SMON_REGS-1:0]  cfg_write;
  logic [SMON_REGS-1:0]  cfg_read;
  smon_word_t            cfg_wdata;
  logic                  cfg_ack;
  logic                  cfg_err;
  smon_word_t            cfg_rdata;
  logic [SMON_LANES-1:0] mon_v;
  smon_word_t            mon_comp [SMON_LANES];
  smon_word_t            mon_val  [SMON_LANES];
  logic                  smon_interrupt;
  logic                  smon_enabled;

  // step table, inputs and the expected outputs for each cycle
  string                 t_name      [MAX_STEPS];
  logic [SMON_REGS-1:0]  t_write     [MAX_STEPS];
  logic [SMON_REGS-1:0]  t_read      [MAX_STEPS];
  smon_word_t            t_wdata     [MAX_STEPS];
  logic [SMON_LANES-1:0] t_v         [MAX_STEPS];
  smon_word_t            t_comp      [MAX_STEPS][SMON_LANES];
  smon_word_t            t_val       [MAX_STEPS][SMON_LANES];
  logic                  t_dis       [MAX_STEPS];
  smon_word_t            t_exp_rdata [MAX_STEPS];
  logic                  t_exp_ack   [MAX_STEPS];
  logic                  t_exp_err   [MAX_STEPS];
  logic                  t_exp_int   [MAX_STEPS];
  logic                  t_exp_en    [MAX_STEPS];
  int                    n_steps = 0;

  // inputs of the step being built
  logic [SMON_REGS-1:0]  s_write;
  logic [SMON_REGS-1:0]  s_read;
  smon_word_t            s_wdata;
  logic [SMON_LANES-1:0] s_v;
  smon_word_t            s_comp [SMON_LANES];
  smon_word_t            s_val  [SMON_LANES];
  logic                  s_dis = 1'b0;

  // model state, register contents and whether the last edge took counter 0
  // from at most the threshold to above it
  smon_word_t            m_regs [SMON_REGS];
  logic                  m_crossed = 1'b0;

  int                    seed;
  int                    cycles = 0;
  int                    limit = MAX_STEPS + 20;
  int                    pulses = 0;

  tb_clock_gen i_tb_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  smon_top i_smon_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .disable_smon   (disable_smon),
    .cfg_write      (cfg_write),
    .cfg_read       (cfg_read),
    .cfg_wdata      (cfg_wdata),
    .cfg_ack        (cfg_ack),
    .cfg_err        (cfg_err),
    .cfg_rdata      (cfg_rdata),
    .mon_v          (mon_v),
    .mon_comp       (mon_comp),
    .mon_val        (mon_val),
    .smon_interrupt (smon_interrupt),
    .smon_enabled   (smon_enabled)
  );

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_word(input string name, input smon_word_t exp, input smon_word_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      $display("Test failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  // --------------------
  // reference model and table building
  // --------------------

  function automatic smon_word_t ctrl_word(input logic en, input smon_mode_e mode,
                                           input int sel0, input int sel1);
    smon_word_t w;
    w = '0;
    w[CTRL_EN_BIT] = en;
    w[CTRL_MODE_LSB +: 2] = mode;
    w[CTRL_SEL0_LSB +: SMON_SEL_W] = SMON_SEL_W'(sel0);
    w[CTRL_SEL1_LSB +: SMON_SEL_W] = SMON_SEL_W'(sel1);
    return w;
  endfunction

  // records the staged inputs with the outputs the rules predict, then
  // advances the model across one rising edge
  task automatic push_step(input string name);
    logic [2*SMON_REGS-1:0] strobes;
    logic                   err;
    logic                   en;
    int                     ones;
    int                     c;
    smon_word_t             nxt [SMON_REGS];
    smon_mode_e             mode;
    logic [SMON_SEL_W-1:0]  sel;
    if (n_steps >= MAX_STEPS) begin
      $display("the step table is full, raise MAX_STEPS");
      $display("Test failed");
      $fatal(1, "table overflow");
    end
    strobes = {s_read, s_write};
    ones = 0;
    for (int i = 0; i < 2 * SMON_REGS; i++) begin
      if (strobes[i]) ones++;
    end
    err = ones > 1;
    en = m_regs[REG_CTRL][CTRL_EN_BIT] && !s_dis;
    t_name[n_steps] = name;
    t_write[n_steps] = s_write;
    t_read[n_steps] = s_read;
    t_wdata[n_steps] = s_wdata;
    t_v[n_steps] = s_v;
    t_dis[n_steps] = s_dis;
    t_comp[n_steps] = s_comp;
    t_val[n_steps] = s_val;
    t_exp_rdata[n_steps] = '0;
    for (int i = 0; i < SMON_REGS; i++) begin
      if (!err && s_read[i]) t_exp_rdata[n_steps] = m_regs[i];
    end
    t_exp_ack[n_steps] = ones != 0;
    t_exp_err[n_steps] = err;
    t_exp_en[n_steps] = en;
    t_exp_int[n_steps] = en && m_crossed;
    // rising edge of the model
    nxt = m_regs;
    mode = smon_mode_e'(m_regs[REG_CTRL][CTRL_MODE_LSB +: 2]);
    if (en) begin
      if (m_regs[REG_TIMER] == m_regs[REG_TIMER_MAX]) begin
        nxt[REG_CTRL][CTRL_EN_BIT] = 1'b0;
      end else begin
        nxt[REG_TIMER] = m_regs[REG_TIMER] + 32'd1;
      end
      for (int k = 0; k < 2; k++) begin
        c = REG_CNT0 + k;
        if (k == 0) sel = m_regs[REG_CTRL][CTRL_SEL0_LSB +: SMON_SEL_W];
        else sel = m_regs[REG_CTRL][CTRL_SEL1_LSB +: SMON_SEL_W];
        if (s_v[sel] && s_comp[sel] == m_regs[REG_CMP0 + k]) begin
          case (mode)
            MODE_COUNT: nxt[c] = m_regs[c] + 32'd1;
            MODE_SUM:   nxt[c] = m_regs[c] + s_val[sel];
            MODE_MAX:   if (s_val[sel] > m_regs[c]) nxt[c] = s_val[sel];
            default:    ;
          endcase
        end
      end
    end
    for (int i = 0; i < SMON_REGS; i++) begin
      if (!err && s_write[i]) nxt[i] = s_wdata;
    end
    // a crossing is counter 0 going from at most the threshold to above it
    m_crossed = (m_regs[REG_CNT0] <= m_regs[REG_THRESH]) &&
                (nxt[REG_CNT0] > nxt[REG_THRESH]);
    m_regs = nxt;
    n_steps++;
  endtask

  // disable_smon is left as it is, it spans several steps
  task automatic clear_stage();
    s_write = '0;
    s_read = '0;
    s_wdata = '0;
    s_v = '0;
    for (int l = 0; l < SMON_LANES; l++) begin
      s_comp[l] = '0;
      s_val[l] = '0;
    end
  endtask

  task automatic write_reg(input string name, input int idx, input smon_word_t data);
    clear_stage();
    s_write = 8'b1 << idx;
    s_wdata = data;
    push_step(name);
  endtask

  task automatic read_reg(input string name, input int idx);
    clear_stage();
    s_read = 8'b1 << idx;
    push_step(name);
  endtask

  task automatic lane_sample(input string name, input int lane, input smon_word_t tag,
                             input smon_word_t value, input logic valid);
    clear_stage();
    s_v[lane] = valid;
    s_comp[lane] = tag;
    s_val[lane] = value;
    push_step(name);
  endtask

  task automatic build_table();
    smon_word_t rnd;
    smon_word_t pick;
    for (int i = 0; i < SMON_REGS; i++) m_regs[i] = '0;
    // register read-back, then rejected two-hot accesses
    for (int i = 0; i < SMON_REGS; i++) write_reg("reg_write", i, {8'h5A, 8'(i), 16'hC3C2});
    for (int i = 0; i < SMON_REGS; i++) read_reg("reg_readback", i);
    clear_stage();
    s_write = 8'b0000_0011;
    s_wdata = '1;
    push_step("two_hot_write");
    clear_stage();
    s_write = 8'b0000_0100;
    s_read = 8'b0000_0100;
    s_wdata = '1;
    push_step("read_with_write");
    for (int i = 0; i < 3; i++) read_reg("after_err_readback", i);
    for (int i = 0; i < SMON_REGS; i++) write_reg("reg_clear", i, '0);
    // count mode on lane 3
    write_reg("cnt_setup", REG_CMP0, TAG0);
    write_reg("cnt_setup", REG_THRESH, '1);
    write_reg("cnt_setup", REG_TIMER_MAX, 32'd1000);
    write_reg("cnt_setup", REG_CTRL, ctrl_word(1'b1, MODE_COUNT, 3, 5));
    for (int i = 0; i < 3; i++) lane_sample("cnt_match", 3, TAG0, 32'd7, 1'b1);
    lane_sample("cnt_bad_tag", 3, TAG0 ^ 32'd1, 32'd7, 1'b1);
    lane_sample("cnt_other_lane", 2, TAG0, 32'd7, 1'b1);
    lane_sample("cnt_not_valid", 3, TAG0, 32'd7, 1'b0);
    read_reg("cnt_result", REG_CNT0);
    // sum and then max on lane 5, random values with a random tag match
    write_reg("sum_setup", REG_CTRL, '0);
    write_reg("sum_setup", REG_CMP1, TAG1);
    write_reg("sum_setup", REG_CNT1, '0);
    write_reg("sum_setup", REG_TIMER, '0);
    write_reg("sum_setup", REG_CTRL, ctrl_word(1'b1, MODE_SUM, 3, 5));
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      pick = $random(seed);
      lane_sample("sum_sample", 5, pick[0] ? TAG1 : TAG1 + 32'd1, rnd, 1'b1);
    end
    read_reg("sum_result", REG_CNT1);
    write_reg("max_setup", REG_CTRL, '0);
    write_reg("max_setup", REG_CNT1, '0);
    write_reg("max_setup", REG_CTRL, ctrl_word(1'b1, MODE_MAX, 3, 5));
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      pick = $random(seed);
      lane_sample("max_sample", 5, pick[0] ? TAG1 : TAG1 + 32'd1, rnd, 1'b1);
    end
    read_reg("max_result", REG_CNT1);
    // timer limit of 5 ends the run and freezes counter 0
    write_reg("tmr_setup", REG_CTRL, '0);
    write_reg("tmr_setup", REG_CNT0, '0);
    write_reg("tmr_setup", REG_TIMER, '0);
    write_reg("tmr_setup", REG_TIMER_MAX, 32'd5);
    write_reg("tmr_setup", REG_CTRL, ctrl_word(1'b1, MODE_COUNT, 3, 5));
    for (int i = 0; i < 9; i++) lane_sample("tmr_run", 3, TAG0, '0, 1'b1);
    read_reg("tmr_timer", REG_TIMER);
    read_reg("tmr_cnt0", REG_CNT0);
    // threshold of 2 crossed on the third match, then the external disable
    write_reg("thr_setup", REG_CTRL, '0);
    write_reg("thr_setup", REG_CNT0, '0);
    write_reg("thr_setup", REG_TIMER, '0);
    write_reg("thr_setup", REG_TIMER_MAX, 32'd1000);
    write_reg("thr_setup", REG_THRESH, 32'd2);
    write_reg("thr_setup", REG_CTRL, ctrl_word(1'b1, MODE_COUNT, 3, 5));
    for (int i = 0; i < 5; i++) lane_sample("thr_count", 3, TAG0, '0, 1'b1);
    for (int i = 0; i < 2; i++) lane_sample("thr_idle", 0, '0, '0, 1'b0);
    s_dis = 1'b1;
    for (int i = 0; i < 3; i++) lane_sample("dis_sample", 3, TAG0, '0, 1'b1);
    read_reg("dis_cnt0", REG_CNT0);
    s_dis = 1'b0;
    read_reg("dis_release", REG_CNT0);
  endtask

  // --------------------
  // run
  // --------------------

  initial begin
    seed = 20869;
    disable_smon = 1'b0;
    cfg_write = '0;
    cfg_read = '0;
    cfg_wdata = '0;
    mon_v = '0;
    for (int l = 0; l < SMON_LANES; l++) begin
      mon_comp[l] = '0;
      mon_val[l] = '0;
    end
    build_table();
    limit = n_steps + 20;
    @(posedge arst_n);
    for (int s = 0; s < n_steps; s++) begin
      @(negedge clk);
      cfg_write = t_write[s];
      cfg_read = t_read[s];
      cfg_wdata = t_wdata[s];
      mon_v = t_v[s];
      disable_smon = t_dis[s];
      mon_comp = t_comp[s];
      mon_val = t_val[s];
      // outputs have settled well before the next rising edge
      #1;
      check_word({t_name[s], " cfg_rdata"}, t_exp_rdata[s], cfg_rdata);
      check_bit({t_name[s], " cfg_ack"}, t_exp_ack[s], cfg_ack);
      check_bit({t_name[s], " cfg_err"}, t_exp_err[s], cfg_err);
      check_bit({t_name[s], " smon_interrupt"}, t_exp_int[s], smon_interrupt);
      check_bit({t_name[s], " smon_enabled"}, t_exp_en[s], smon_enabled);
      if (smon_interrupt) pulses++;
    end
    @(negedge clk);
    // only the threshold test crosses, so exactly one pulse over the whole run
    check_word("interrupt pulse count", 32'd1, smon_word_t'(pulses));
    $display("Test passed");
    $finish;
  end

  // the table runs one step per cycle, so its length bounds the run
  always @(posedge clk) begin
    if (arst_n) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("timeout, the step table did not finish within %0d cycles", limit);
        $display("Test failed");
        $fatal(1, "timeout");
      end
    end
  end

endmodule

`default_nettype wire

/* files.f */
source/smon_pkg.sv
source/smon_cfg_if.sv
source/smon_cfg_decode.sv
source/smon_counter.sv
source/smon_threshold.sv
source/smon_top.sv
testbench/tb_clock_gen.sv
testbench/tb_smon_top.sv

/* Makefile */
# Verilator lint, build and simulation of the statistics monitor testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_smon_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail, a missing pass line fails the target
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
